/* design/rv_pipe_pkg.sv */
package rv_pipe_pkg;

    localparam int xlen       = 32;
    localparam int reg_idx_w  = 5;
    localparam int shamt_w    = $clog2(xlen);
    localparam int dmem_depth = 256;
    localparam int dmem_idx_w = $clog2(dmem_depth);

    localparam logic [xlen-1:0] int_min   = {1'b1, {(xlen-1){1'b0}}};
    localparam logic [xlen-1:0] minus_one = {xlen{1'b1}};

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        res_alu       = 3'd0,
        res_mem       = 3'd1,
        res_pc_plus4  = 3'd2,
        res_imm       = 3'd3,
        res_mul       = 3'd4,
        res_quotient  = 3'd5,
        res_remainder = 3'd6,
        res_pc_target = 3'd7
    } result_src_e;

    // remaining codes behave as a word store.
    typedef enum logic [2:0] {
        st_byte = 3'd0,
        st_half = 3'd1,
        st_word = 3'd2
    } store_src_e;

    typedef union packed {
        logic [xlen-1:0]   word;
        logic [3:0][7:0]   bytes;
        logic [1:0][15:0]  halves;
    } mem_word_u;

endpackage

/* design/ex_mem_if.sv */
interface ex_mem_if
    import rv_pipe_pkg::*;
();

    logic [xlen-1:0]      alu_result;
    logic [xlen-1:0]      write_data;
    logic [xlen-1:0]      imm_ext;
    logic [xlen-1:0]      mul_out;
    logic [xlen-1:0]      quotient;
    logic [xlen-1:0]      remainder;
    logic [xlen-1:0]      pc_plus4;
    logic [xlen-1:0]      pc_target;
    logic [reg_idx_w-1:0] rd;
    result_src_e          result_src;
    store_src_e           store_src;
    logic                 reg_write;
    logic                 mem_write;

    modport exec (
        output alu_result, write_data, imm_ext, mul_out, quotient, remainder,
        output pc_plus4, pc_target, rd,
        output result_src, store_src, reg_write, mem_write
    );

    // the register reads this view on the e side and drives it on the m side.
    modport pipe (
        output alu_result, write_data, imm_ext, mul_out, quotient, remainder,
        output pc_plus4, pc_target, rd,
        output result_src, store_src, reg_write, mem_write
    );

    modport mem (
        input alu_result, write_data, imm_ext, mul_out, quotient, remainder,
        input pc_plus4, pc_target, rd,
        input result_src, store_src, reg_write, mem_write
    );

endinterface

/* design/exec_stage.sv */
module exec_stage
    import rv_pipe_pkg::*;
(
    input  logic [xlen-1:0]      operand_a,
    input  logic [xlen-1:0]      operand_b,
    input  logic [xlen-1:0]      imm,
    input  logic [xlen-1:0]      pc,
    input  logic [reg_idx_w-1:0] rd,
    input  alu_op_e              alu_op,
    input  result_src_e          result_src,
    input  store_src_e           store_src,
    input  logic                 reg_write,
    input  logic                 mem_write,
    ex_mem_if.exec               e_bus
);

    logic [shamt_w-1:0]       shamt;
    logic                     lt_signed;
    logic                     lt_unsigned;
    logic [xlen-1:0]          alu_y;
    logic [xlen-1:0]          product;
    logic [xlen-1:0]          div_q;
    logic [xlen-1:0]          div_r;

    assign shamt       = operand_b[shamt_w-1:0];
    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    always_comb begin
        case (alu_op)
            alu_add:  alu_y = operand_a + operand_b;
            alu_sub:  alu_y = operand_a - operand_b;
            alu_and:  alu_y = operand_a & operand_b;
            alu_or:   alu_y = operand_a | operand_b;
            alu_xor:  alu_y = operand_a ^ operand_b;
            alu_sll:  alu_y = operand_a << shamt;
            alu_srl:  alu_y = operand_a >> shamt;
            alu_sra:  alu_y = $signed(operand_a) >>> shamt;
            alu_slt:  alu_y = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: alu_y = {{(xlen-1){1'b0}}, lt_unsigned};
            default:  alu_y = '0;
        endcase
    end

    // only the low word of the signed product is kept.
    assign product = $signed(operand_a) * $signed(operand_b);

    always_comb begin
        if (operand_b == '0) begin
            div_q = minus_one;                        // riscv divide by zero.
            div_r = operand_a;
        end else if (operand_a == int_min && operand_b == minus_one) begin
            div_q = int_min;                          // signed overflow.
            div_r = '0;
        end else begin
            div_q = $signed(operand_a) / $signed(operand_b);
            div_r = $signed(operand_a) % $signed(operand_b);
        end
    end

    assign e_bus.alu_result = alu_y;
    assign e_bus.write_data = operand_b;
    assign e_bus.imm_ext    = imm;
    assign e_bus.mul_out    = product;
    assign e_bus.quotient   = div_q;
    assign e_bus.remainder  = div_r;
    assign e_bus.pc_plus4   = pc + xlen'(4);
    assign e_bus.pc_target  = pc + imm;
    assign e_bus.rd         = rd;
    assign e_bus.result_src = result_src;
    assign e_bus.store_src  = store_src;
    assign e_bus.reg_write  = reg_write;
    assign e_bus.mem_write  = mem_write;

endmodule

/* design/ex_mem_reg.sv */
module ex_mem_reg
    import rv_pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    ex_mem_if.pipe e_bus,
    ex_mem_if.pipe m_bus
);

    // no enable, every field advances each clock.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_bus.alu_result <= '0;
            m_bus.write_data <= '0;
            m_bus.imm_ext    <= '0;
            m_bus.mul_out    <= '0;
            m_bus.quotient   <= '0;
            m_bus.remainder  <= '0;
            m_bus.pc_plus4   <= '0;
            m_bus.pc_target  <= '0;
            m_bus.rd         <= '0;
            m_bus.result_src <= res_alu;
            m_bus.store_src  <= st_byte;
            m_bus.reg_write  <= 1'b0;                 // no writeback out of reset.
            m_bus.mem_write  <= 1'b0;                 // no stray store out of reset.
        end else begin
            m_bus.alu_result <= e_bus.alu_result;
            m_bus.write_data <= e_bus.write_data;
            m_bus.imm_ext    <= e_bus.imm_ext;
            m_bus.mul_out    <= e_bus.mul_out;
            m_bus.quotient   <= e_bus.quotient;
            m_bus.remainder  <= e_bus.remainder;
            m_bus.pc_plus4   <= e_bus.pc_plus4;
            m_bus.pc_target  <= e_bus.pc_target;
            m_bus.rd         <= e_bus.rd;
            m_bus.result_src <= e_bus.result_src;
            m_bus.store_src  <= e_bus.store_src;
            m_bus.reg_write  <= e_bus.reg_write;
            m_bus.mem_write  <= e_bus.mem_write;
        end
    end

endmodule

/* design/mem_stage.sv */
module mem_stage
    import rv_pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    ex_mem_if.mem                m_bus,
    output logic [xlen-1:0]      wb_data,
    output logic [reg_idx_w-1:0] wb_rd,
    output logic                 wb_reg_write
);

    mem_word_u             dmem [dmem_depth];
    logic [dmem_idx_w-1:0] word_idx;
    mem_word_u             rd_word;
    mem_word_u             st_word;
    logic [xlen-1:0]       result;

    assign word_idx = m_bus.alu_result[dmem_idx_w+1:2];   // drop the byte offset.
    assign rd_word  = dmem[word_idx];

    // merge the store data into the current word, lane by lane.
    always_comb begin
        st_word = rd_word;
        case (m_bus.store_src)
            st_byte: st_word.bytes[m_bus.alu_result[1:0]] = m_bus.write_data[7:0];
            st_half: st_word.halves[m_bus.alu_result[1]]  = m_bus.write_data[15:0];
            default: st_word.word = m_bus.write_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (m_bus.mem_write) begin
            dmem[word_idx] <= st_word;
        end
    end

    always_comb begin
        case (m_bus.result_src)
            res_alu:       result = m_bus.alu_result;
            res_mem:       result = rd_word.word;     // loads return the full word.
            res_pc_plus4:  result = m_bus.pc_plus4;
            res_imm:       result = m_bus.imm_ext;
            res_mul:       result = m_bus.mul_out;
            res_quotient:  result = m_bus.quotient;
            res_remainder: result = m_bus.remainder;
            res_pc_target: result = m_bus.pc_target;
            default:       result = m_bus.alu_result;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_data      <= '0;
            wb_rd        <= '0;
            wb_reg_write <= 1'b0;
        end else begin
            wb_data      <= result;
            wb_rd        <= m_bus.rd;
            wb_reg_write <= m_bus.reg_write;
        end
    end

endmodule

/* design/exec_mem_top.sv */
module exec_mem_top
    import rv_pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [xlen-1:0]      operand_a,
    input  logic [xlen-1:0]      operand_b,
    input  logic [xlen-1:0]      imm,
    input  logic [xlen-1:0]      pc,
    input  logic [reg_idx_w-1:0] rd,
    input  alu_op_e              alu_op,
    input  result_src_e          result_src,
    input  store_src_e           store_src,
    input  logic                 reg_write,
    input  logic                 mem_write,
    output logic [xlen-1:0]      wb_data,
    output logic [reg_idx_w-1:0] wb_rd,
    output logic                 wb_reg_write
);

    ex_mem_if e_bus ();                               // execute side.
    ex_mem_if m_bus ();                               // memory side.

    exec_stage exec_stage_inst (
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .imm        (imm),
        .pc         (pc),
        .rd         (rd),
        .alu_op     (alu_op),
        .result_src (result_src),
        .store_src  (store_src),
        .reg_write  (reg_write),
        .mem_write  (mem_write),
        .e_bus      (e_bus.exec)
    );

    ex_mem_reg ex_mem_reg_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .e_bus (e_bus.pipe),
        .m_bus (m_bus.pipe)
    );

    mem_stage mem_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .m_bus        (m_bus.mem),
        .wb_data      (wb_data),
        .wb_rd        (wb_rd),
        .wb_reg_write (wb_reg_write)
    );

endmodule

/* dv/exec_mem_assert.sv */
module exec_mem_assert
    import rv_pipe_pkg::*;
(
    input logic                          clk,
    input logic                          rst_n,
    input logic [1:0]                    strobes,
    input logic [8*xlen+reg_idx_w+7:0]   stage_in,
    input logic [8*xlen+reg_idx_w+7:0]   stage_out
);

    int fail_count = 0;

    strobes_idle_in_reset: assert property (@(posedge clk) !rst_n |-> strobes == 2'b00)
        else begin
            $error("write strobe active while reset is asserted");
            fail_count++;
        end

    // one register stage, so the output is last cycle's input.
    stage_follows_input: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> stage_out == $past(stage_in))
        else begin
            $error("stage output does not match the input of the previous cycle");
            fail_count++;
        end

endmodule

bind ex_mem_reg exec_mem_assert reg_checks (
    .clk       (clk),
    .rst_n     (rst_n),
    .strobes   ({m_bus.reg_write, m_bus.mem_write}),
    .stage_in  ({e_bus.alu_result, e_bus.write_data, e_bus.imm_ext, e_bus.mul_out,
                 e_bus.quotient, e_bus.remainder, e_bus.pc_plus4, e_bus.pc_target,
                 e_bus.rd, e_bus.result_src, e_bus.store_src, e_bus.reg_write,
                 e_bus.mem_write}),
    .stage_out ({m_bus.alu_result, m_bus.write_data, m_bus.imm_ext, m_bus.mul_out,
                 m_bus.quotient, m_bus.remainder, m_bus.pc_plus4, m_bus.pc_target,
                 m_bus.rd, m_bus.result_src, m_bus.store_src, m_bus.reg_write,
                 m_bus.mem_write})
);

bind mem_stage exec_mem_assert wb_checks (
    .clk       (clk),
    .rst_n     (rst_n),
    .strobes   ({wb_reg_write, 1'b0}),
    .stage_in  ({{(8*rv_pipe_pkg::xlen+7){1'b0}}, m_bus.rd, m_bus.reg_write}),
    .stage_out ({{(8*rv_pipe_pkg::xlen+7){1'b0}}, wb_rd, wb_reg_write})
);

/* dv/exec_mem_tb.sv */
module exec_mem_tb
    import rv_pipe_pkg::*;
();

    typedef struct {
        logic [xlen-1:0]      data;
        logic [reg_idx_w-1:0] rd;
        logic                 wr;
        int                   due;
    } exp_entry_t;

    logic                 clk;
    logic                 rst_n;
    logic [xlen-1:0]      operand_a;
    logic [xlen-1:0]      operand_b;
    logic [xlen-1:0]      imm;
    logic [xlen-1:0]      pc;
    logic [reg_idx_w-1:0] rd;
    alu_op_e              alu_op;
    result_src_e          result_src;
    store_src_e           store_src;
    logic                 reg_write;
    logic                 mem_write;
    logic [xlen-1:0]      wb_data;
    logic [reg_idx_w-1:0] wb_rd;
    logic                 wb_reg_write;

    mem_word_u            mirror [dmem_depth];
    exp_entry_t           exp_q [$];
    exp_entry_t           due_entry;
    int                   seed = 11341;
    int                   cycle_cnt = 0;
    int                   check_count = 0;
    int                   error_count = 0;
    int                   test_checks0 = 0;
    int                   test_errs0 = 0;
    int                   i;
    logic [xlen-1:0]      rnd_a;
    logic [xlen-1:0]      rnd_b;
    logic [xlen-1:0]      addr;
    logic [xlen-1:0]      data;

    exec_mem_top exec_mem_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic logic [xlen-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [xlen-1:0] alu_ref(input logic [xlen-1:0] a, b, input alu_op_e op);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << sh;
            alu_srl:  return a >> sh;
            alu_sra:  return (a >> sh) | (a[xlen-1] ? ~(minus_one >> sh) : {xlen{1'b0}});
            alu_slt:  return (a[xlen-1] != b[xlen-1]) ? xlen'(a[xlen-1]) : xlen'(a < b);
            alu_sltu: return xlen'(a < b);
            default:  return {xlen{1'b0}};
        endcase
    endfunction

    // quotient in the upper word, remainder in the lower.
    function automatic logic [2*xlen-1:0] div_ref(input logic [xlen-1:0] a, b);
        logic [xlen-1:0] ua;
        logic [xlen-1:0] ub;
        logic [xlen-1:0] uq;
        logic [xlen-1:0] ur;
        if (b == 0) return {minus_one, a};
        if (a == int_min && b == minus_one) return {int_min, {xlen{1'b0}}};
        ua = a[xlen-1] ? -a : a;                      // magnitudes, then fix the signs.
        ub = b[xlen-1] ? -b : b;
        uq = ua / ub;
        ur = ua % ub;
        if (a[xlen-1] != b[xlen-1]) uq = -uq;
        if (a[xlen-1]) ur = -ur;
        return {uq, ur};
    endfunction

    function automatic logic [xlen-1:0] predict_result(input logic [xlen-1:0] a, b, imm_v,
                                                       input logic [xlen-1:0] pc_v, load_word,
                                                       input alu_op_e op,
                                                       input result_src_e src);
        logic [2*xlen-1:0] qr;
        qr = div_ref(a, b);
        case (src)
            res_alu:       return alu_ref(a, b, op);
            res_mem:       return load_word;
            res_pc_plus4:  return pc_v + 4;
            res_imm:       return imm_v;
            res_mul:       return a * b;              // low word is sign independent.
            res_quotient:  return qr[2*xlen-1:xlen];
            res_remainder: return qr[xlen-1:0];
            default:       return pc_v + imm_v;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [xlen-1:0] expected,
                              input logic [xlen-1:0] actual);
        check_count++;
        assert (actual === expected)
            else begin
                $display("FAIL %s expected %h actual %h", name, expected, actual);
                error_count++;
            end
    endtask

    task automatic drive_bubble();
        operand_a  <= '0;
        operand_b  <= '0;
        imm        <= '0;
        pc         <= '0;
        rd         <= '0;
        alu_op     <= alu_add;
        result_src <= res_alu;
        store_src  <= st_word;
        reg_write  <= 1'b0;
        mem_write  <= 1'b0;
    endtask

    task automatic issue(input logic [xlen-1:0] a, b, imm_v, pc_v,
                         input logic [reg_idx_w-1:0] rd_v, input alu_op_e op,
                         input result_src_e src, input store_src_e st, input logic wr, mw);
        exp_entry_t                e;
        logic [xlen-1:0]           ea;
        logic [dmem_idx_w-1:0]     idx;
        @(negedge clk);
        operand_a  <= a;
        operand_b  <= b;
        imm        <= imm_v;
        pc         <= pc_v;
        rd         <= rd_v;
        alu_op     <= op;
        result_src <= src;
        store_src  <= st;
        reg_write  <= wr;
        mem_write  <= mw;
        ea = alu_ref(a, b, op);
        idx = ea[dmem_idx_w+1:2];
        e.data = predict_result(a, b, imm_v, pc_v, mirror[idx].word, op, src);
        e.rd = rd_v;
        e.wr = wr;
        e.due = cycle_cnt + 2;
        exp_q.push_back(e);
        if (mw) begin
            case (st)
                st_byte: mirror[idx].bytes[ea[1:0]] = b[7:0];
                st_half: mirror[idx].halves[ea[1]] = b[15:0];
                default: mirror[idx].word = b;
            endcase
        end
    endtask

    task automatic muldiv(input logic [xlen-1:0] a, b);
        issue(a, b, 0, 0, reg_idx_w'(rand_word()), alu_add, res_mul, st_word, 1'b1, 1'b0);
        issue(a, b, 0, 0, reg_idx_w'(rand_word()), alu_add, res_quotient, st_word, 1'b1, 1'b0);
        issue(a, b, 0, 0, reg_idx_w'(rand_word()), alu_add, res_remainder, st_word, 1'b1, 1'b0);
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(negedge clk);
            drive_bubble();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected results never reached the writeback", exp_q.size());
            error_count++;
            exp_q.delete();
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s done: %0d checks, %0d errors", name, check_count - test_checks0,
                 error_count - test_errs0);
        test_checks0 = check_count;
        test_errs0 = error_count;
    endtask

    // results come out two edges after the instruction was driven.
    always @(negedge clk) begin
        if (exp_q.size() > 0 && exp_q[0].due == cycle_cnt) begin
            due_entry = exp_q.pop_front();
            check_word("wb_data", due_entry.data, wb_data);
            check_word("wb_rd", xlen'(due_entry.rd), xlen'(wb_rd));
            check_word("wb_reg_write", xlen'(due_entry.wr), xlen'(wb_reg_write));
        end
    end

    initial begin
        rst_n = 1'b0;
        operand_a = '0;
        operand_b = '0;
        imm = '0;
        pc = '0;
        rd = '0;
        alu_op = alu_add;
        result_src = res_alu;
        store_src = st_word;
        reg_write = 1'b0;
        mem_write = 1'b0;

        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            check_word("wb_reg_write", 0, xlen'(wb_reg_write));
            check_word("wb_data", 0, wb_data);
            reg_write <= 1'b1;                        // must not leak through reset.
            result_src <= res_imm;
            imm <= rand_word();
        end
        rst_n <= 1'b1;
        drive_bubble();
        issue(0, 0, 0, 0, 0, alu_add, res_alu, st_word, 1'b0, 1'b0);
        check_word("wb_reg_write", 0, xlen'(wb_reg_write));
        check_word("wb_data", 0, wb_data);
        issue(0, 0, 0, 0, 0, alu_add, res_alu, st_word, 1'b0, 1'b0);
        wait_drained(20);
        report_test("reset");

        for (i = 0; i < 200; i++) begin
            issue(rand_word(), rand_word(), 0, 0, reg_idx_w'(rand_word()),
                  alu_op_e'($unsigned(rand_word()) % 10), res_alu, st_word, 1'b1, 1'b0);
        end
        wait_drained(20);
        report_test("alu");

        muldiv(32'd1234, 0);
        muldiv(32'hffff_fff9, 0);
        muldiv(int_min, minus_one);
        muldiv(32'hffff_fff9, 32'd2);
        muldiv(32'd7, 32'hffff_fffe);
        muldiv(32'hffff_fff9, 32'hffff_fffe);
        muldiv(int_min, 32'd1);
        muldiv(0, 0);
        for (i = 0; i < 60; i++) begin
            muldiv(rand_word(), rand_word());
        end
        wait_drained(20);
        report_test("muldiv");

        for (i = 0; i < 60; i++) begin
            rnd_a = rand_word();
            rnd_b = rand_word();
            issue(0, 0, rnd_a, rnd_b, reg_idx_w'(rand_word()), alu_add,
                  (i % 3 == 0) ? res_imm : ((i % 3 == 1) ? res_pc_plus4 : res_pc_target),
                  st_word, 1'b1, 1'b0);
        end
        wait_drained(20);
        report_test("passthru");

        for (i = 0; i < dmem_depth; i++) begin
            addr = xlen'(i) << 2;
            data = (32'h9e37_79b9 * (xlen'(i) + 1)) ^ (xlen'(i) << 16);
            issue(addr - data, data, 0, 0, 0, alu_add, res_alu, st_word, 1'b0, 1'b1);
        end
        for (i = 0; i < 80; i++) begin
            addr = rand_word() & 32'h0000_03ff;
            data = rand_word();
            issue(addr - data, data, 0, 0, 0, alu_add, res_alu,
                  store_src_e'($unsigned(rand_word()) % 3), 1'b0, 1'b1);
            issue(addr, 0, 0, 0, reg_idx_w'(rand_word()), alu_add, res_mem, st_word, 1'b1, 1'b0);
        end
        wait_drained(20);
        report_test("load_store");

        addr = rand_word() & 32'h0000_03fc;
        data = rand_word();
        issue(addr - data, data, 0, 0, 0, alu_add, res_alu, st_word, 1'b0, 1'b1);
        issue(addr, 0, 0, 0, 5'd3, alu_add, res_mem, st_word, 1'b1, 1'b0);
        for (i = 0; i < 40; i++) begin
            rnd_b = rand_word();
            issue(addr - rnd_b, rnd_b, 0, 0, reg_idx_w'(rand_word()), alu_add, res_alu,
                  store_src_e'($unsigned(rand_word()) % 3), 1'(rand_word()), 1'b0);
        end
        issue(addr, 0, 0, 0, 5'd7, alu_add, res_mem, st_word, 1'b1, 1'b0);
        wait_drained(20);
        report_test("strobes");

        error_count += exec_mem_top_inst.ex_mem_reg_inst.reg_checks.fail_count;
        error_count += exec_mem_top_inst.mem_stage_inst.wb_checks.fail_count;
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sim.f */
design/rv_pipe_pkg.sv
design/ex_mem_if.sv
design/exec_stage.sv
design/ex_mem_reg.sv
design/mem_stage.sv
design/exec_mem_top.sv
dv/exec_mem_assert.sv
dv/exec_mem_tb.sv
